//--- fp_demo_pkg.sv
package fp_demo_pkg;

    // one single-precision value as raw bits
    typedef logic [31:0] fp32_t;

    typedef logic [7:0]  fp_exp_t;   // biased exponent
    typedef logic [22:0] fp_frac_t;  // stored fraction without hidden one

    // ieee-754 layout of fp32_t
    typedef struct packed
    {
        logic     sign;
        fp_exp_t  exp;
        fp_frac_t frac;
    } fp_fields_t;

    // operand pair from the key table
    typedef struct packed
    {
        fp32_t a;
        fp32_t b;
    } fp_pair_t;

    // result classes, at most one set
    typedef struct packed
    {
        logic zero;
        logic pos_inf;
        logic neg_inf;
        logic nan;
    } fp_flags_t;

    typedef logic [15:0] hex_word_t;  // four nibbles on the display

    // segments a..g plus dot, a in the msb, active low
    typedef logic [7:0] seg_t;

    // digit enables, active low, bit 0 is the rightmost digit
    typedef logic [3:0] digit_t;

endpackage

//--- fp_operand_table.sv
`timescale 1ns/10ps

// eight operand pairs picked by the keys
// layout per value is sign | exp[7:0] | frac[22:0] as in fp_fields_t
module fp_operand_table
(
    input  logic [2:0]            sel,
    output fp_demo_pkg::fp_pair_t pair
);

    always_comb
    begin
        case (sel)
        3'd0:
        begin
            pair.a = 32'h0000_0000;  // 0.0
            pair.b = 32'h0000_0000;  // 0.0, sum 00000000
        end
        3'd1:
        begin
            pair.a = 32'h0000_0000;  // 0.0
            pair.b = 32'h3f80_0000;  // 1.0, sum 3f800000
        end
        3'd2:
        begin
            pair.a = 32'h3f80_0000;  // 1.0
            pair.b = 32'h3f80_0000;  // 1.0, sum 40000000 (2.0)
        end
        3'd3:
        begin
            pair.a = 32'h3f9d_f3b6;  // 1.234
            pair.b = 32'h40b5_b22d;  // 5.678, sum 40dd2f1a (6.912)
        end
        3'd4:
        begin
            // small addend lies far below half an ulp of the big one
            pair.a = 32'h538f_a811;  // 1.234e12
            pair.b = 32'h40b5_b22d;  // 5.678, sum 538fa811 unchanged
        end
        3'd5:
        begin
            // exponents differ by 4 so the shifted-out bits decide rounding
            pair.a = 32'h3ef3_9f81;  // 0.475826
            pair.b = 32'h3cf0_8e8a;  // 0.029365, sum 3f015435 (0.505191)
        end
        3'd6:
        begin
            pair.a = 32'h7f80_0000;  // +inf
            pair.b = 32'h3cf0_8e8a;  // 0.029365, sum 7f800000
        end
        default:
        begin
            // quiet nan already, passes through as is
            pair.a = 32'h7ffa_bcde;  // nan
            pair.b = 32'h3cf0_8e8a;  // 0.029365, sum 7ffabcde
        end
        endcase
    end

endmodule

//--- fp_adder.sv
`timescale 1ns/10ps

// single precision add with round to nearest even and subnormals flushed to zero
module fp_adder
(
    input  fp_demo_pkg::fp32_t     a,
    input  fp_demo_pkg::fp32_t     b,
    output fp_demo_pkg::fp32_t     sum,
    output fp_demo_pkg::fp_flags_t flags
);

    import fp_demo_pkg::*;

    localparam fp32_t    QNAN_DEFAULT = 32'h7fc0_0000;  // inf minus inf
    localparam fp_frac_t QUIET_BIT    = 23'h40_0000;   // msb of fraction

    fp_fields_t        fa, fb;
    fp_fields_t        big, little;
    fp_fields_t        res;
    logic              a_nan, b_nan;
    logic              a_inf, b_inf;
    logic              a_zero, b_zero;       // zero or flushed subnormal
    logic [30:0]       mag_a, mag_b;
    logic              swap;
    logic              sub;                  // effective subtraction
    logic [23:0]       mant_big, mant_small;
    fp_exp_t           exp_diff;
    logic [4:0]        shamt;
    logic [50:0]       small_wide;
    logic [26:0]       ext_big, ext_small;   // mant, guard, round, sticky
    logic [27:0]       raw;
    logic [4:0]        lz;
    logic [26:0]       norm;
    logic              round_up;
    logic [24:0]       mant_rnd;
    logic signed [9:0] e_norm, e_res;

    // leading zeros of the 27-bit extended significand
    function automatic logic [4:0] lzc27(input logic [26:0] v);
        logic [4:0] n;
        logic       found;
        n     = 5'd0;
        found = 1'b0;
        for (int i = 26; i >= 0; i--)
        begin
            if (!found)
            begin
                if (v[i])
                    found = 1'b1;
                else
                    n = n + 5'd1;
            end
        end
        return n;
    endfunction

    assign fa = a;
    assign fb = b;

    // operand classes
    assign a_nan  = (&fa.exp) &  (|fa.frac);
    assign b_nan  = (&fb.exp) &  (|fb.frac);
    assign a_inf  = (&fa.exp) & ~(|fa.frac);
    assign b_inf  = (&fb.exp) & ~(|fb.frac);
    assign a_zero = ~(|fa.exp);
    assign b_zero = ~(|fb.exp);

    // magnitude order with flushed values counted as zero
    assign mag_a  = a_zero ? 31'd0 : {fa.exp, fa.frac};
    assign mag_b  = b_zero ? 31'd0 : {fb.exp, fb.frac};
    assign swap   = mag_b > mag_a;
    assign big    = swap ? fb : fa;
    assign little = swap ? fa : fb;

    assign mant_big   = (big.exp == 8'd0)    ? 24'd0 : {1'b1, big.frac};
    assign mant_small = (little.exp == 8'd0) ? 24'd0 : {1'b1, little.frac};

    // anything shifted past 27 lands wholly in sticky
    assign exp_diff   = big.exp - little.exp;
    assign shamt      = (exp_diff > 8'd27) ? 5'd27 : exp_diff[4:0];
    assign small_wide = {mant_small, 27'd0} >> shamt;
    assign ext_small  = {small_wide[50:25], |small_wide[24:0]};
    assign ext_big    = {mant_big, 3'b000};

    assign sub = big.sign ^ little.sign;
    assign raw = sub ? {1'b0, ext_big} - {1'b0, ext_small}   // never negative
                     : {1'b0, ext_big} + {1'b0, ext_small};

    // carry out shifts right and keeps sticky
    assign lz   = lzc27(raw[26:0]);
    assign norm = raw[27] ? {raw[27:2], |raw[1:0]} : (raw[26:0] << lz);

    always_comb
    begin
        if (raw[27])
            e_norm = $signed({2'b00, big.exp}) + 10'sd1;
        else
            e_norm = $signed({2'b00, big.exp}) - $signed({5'd0, lz});
    end

    // nearest even with halfway going to the even lsb
    assign round_up = norm[2] & (norm[1] | norm[0] | norm[3]);
    assign mant_rnd = {1'b0, norm[26:3]} + {24'd0, round_up};
    assign e_res    = e_norm + $signed({9'd0, mant_rnd[24]});  // 1.111.. rounds to 10.000..

    // special values override the arithmetic path
    always_comb
    begin
        res = '0;
        if (a_nan)
        begin
            res      = fa;
            res.frac = fa.frac | QUIET_BIT;
        end
        else if (b_nan)
        begin
            res      = fb;
            res.frac = fb.frac | QUIET_BIT;
        end
        else if (a_inf & b_inf & (fa.sign != fb.sign))
            res = QNAN_DEFAULT;
        else if (a_inf)
            res = fa;
        else if (b_inf)
            res = fb;
        else if (raw == 28'd0)
            res.sign = fa.sign & fb.sign;   // -0 only from -0 + -0
        else if (e_res >= 10'sd255)
        begin
            res.sign = big.sign;            // overflow to signed inf
            res.exp  = 8'hff;
        end
        else if (e_res <= 10'sd0)
            res.sign = big.sign;            // below normal range
        else
        begin
            res.sign = big.sign;
            res.exp  = e_res[7:0];
            res.frac = mant_rnd[24] ? 23'd0 : mant_rnd[22:0];
        end
    end

    assign sum = res;

    // flags taken from the final word
    assign flags.zero    = (res.exp == 8'd0) & (res.frac == 23'd0);
    assign flags.pos_inf = (&res.exp) & (res.frac == 23'd0) & ~res.sign;
    assign flags.neg_inf = (&res.exp) & (res.frac == 23'd0) &  res.sign;
    assign flags.nan     = (&res.exp) & (|res.frac);

endmodule

//--- seven_segment_4_digits.sv
`timescale 1ns/10ps

// four digit hex display, scanned by a free running counter
module seven_segment_4_digits
#(
    parameter int REFRESH_BITS = 16
)
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  fp_demo_pkg::hex_word_t number,
    output fp_demo_pkg::seg_t      abcdefgh,
    output fp_demo_pkg::digit_t    digit
);

    import fp_demo_pkg::*;

    logic [REFRESH_BITS-1:0] refresh_cnt;
    logic [1:0]              sel;        // active digit
    logic [3:0]              nibble;
    seg_t                    seg_on;     // active high pattern
    seg_t                    seg_next;
    digit_t                  digit_next;

    assign sel    = refresh_cnt[REFRESH_BITS-1 -: 2];  // top two bits
    assign nibble = number[{sel, 2'b00} +: 4];

    // hex glyphs in abcdefgh order, dot off
    always_comb
    begin
        case (nibble)
        4'h0:    seg_on = 8'b1111_1100;
        4'h1:    seg_on = 8'b0110_0000;
        4'h2:    seg_on = 8'b1101_1010;
        4'h3:    seg_on = 8'b1111_0010;
        4'h4:    seg_on = 8'b0110_0110;
        4'h5:    seg_on = 8'b1011_0110;
        4'h6:    seg_on = 8'b1011_1110;
        4'h7:    seg_on = 8'b1110_0000;
        4'h8:    seg_on = 8'b1111_1110;
        4'h9:    seg_on = 8'b1111_0110;
        4'ha:    seg_on = 8'b1110_1110;
        4'hb:    seg_on = 8'b0011_1110;  // lower case b
        4'hc:    seg_on = 8'b1001_1100;
        4'hd:    seg_on = 8'b0111_1010;  // lower case d
        4'he:    seg_on = 8'b1001_1110;
        default: seg_on = 8'b1000_1110;  // F
        endcase
    end

    assign seg_next   = ~seg_on;                       // board wants active low
    assign digit_next = ~(digit_t'(4'b0001) << sel);   // one-hot low

    // segments and enable change on the same edge
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            refresh_cnt <= '0;
            abcdefgh    <= '1;   // blank
            digit       <= '1;   // no digit lit
        end
        else
        begin
            refresh_cnt <= refresh_cnt + 1'b1;
            abcdefgh    <= seg_next;
            digit       <= digit_next;
        end
    end

endmodule

//--- top.sv
`timescale 1ns/10ps

// board top for the float adder demo
module top
#(
    parameter int REFRESH_BITS = 16
)
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [3:0]          key_sw,     // active low keys
    output logic [3:0]          led,        // active low leds
    output fp_demo_pkg::seg_t   abcdefgh,
    output fp_demo_pkg::digit_t digit,
    output logic                buzzer,
    output logic                hsync,
    output logic                vsync,
    output logic [2:0]          rgb
);

    import fp_demo_pkg::*;

    fp_pair_t  pair;
    fp32_t     sum;
    fp_flags_t flags;
    hex_word_t shown;

    // unused board pins held inactive
    assign buzzer = 1'b0;
    assign hsync  = 1'b1;
    assign vsync  = 1'b1;
    assign rgb    = 3'b000;

    fp_operand_table table0
    (
        .sel  ( ~key_sw[3:1] ),
        .pair ( pair         )
    );

    fp_adder adder0
    (
        .a     ( pair.a ),
        .b     ( pair.b ),
        .sum   ( sum    ),
        .flags ( flags  )
    );

    assign shown = key_sw[0] ? sum[15:0] : sum[31:16];  // pressed key shows upper half

    seven_segment_4_digits #(.REFRESH_BITS(REFRESH_BITS)) display0
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .number   ( shown    ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    assign led = ~flags;   // zero, pos_inf, neg_inf, nan on bits 3..0

endmodule

//--- fp_demo_checker.sv
`timescale 1ns/10ps

// board level rules for leds and display scan
module fp_demo_checker
(
    input logic                clk,
    input logic                rst_n,
    input logic [3:0]          led,     // active low
    input fp_demo_pkg::digit_t digit    // active low
);

    // flags are exclusive, so at most one led pulled low
    led_exclusive: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(~led))
        else $error("more than one led lit, led = %b", led);

    // only one digit driven at a time
    digit_exclusive: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(~digit))
        else $error("more than one digit enabled, digit = %b", digit);

    // reset edge turns every digit off
    digit_off_in_reset: assert property (@(posedge clk) !rst_n |=> digit == 4'hf)
        else $error("digit enables not all high after reset, digit = %b", digit);

endmodule

bind top fp_demo_checker chk0
(
    .clk   ( clk   ),
    .rst_n ( rst_n ),
    .led   ( led   ),
    .digit ( digit )
);

//--- tb_top.sv
`timescale 1ns/10ps

// directed testbench for the float adder board demo
module tb_top;

    import fp_demo_pkg::*;

    localparam int REFRESH_BITS  = 4;
    localparam int CLK_PERIOD_NS = 40;
    localparam int DIGIT_CLOCKS  = 1 << (REFRESH_BITS - 2);  // clocks per lit digit
    localparam int READ_LIMIT    = 16 * DIGIT_CLOCKS;        // wait bound for one digit
    // 24 reads of 4 digits at 16 clocks each with fourfold slack
    localparam int WATCHDOG_NS   = 4 * 24 * 4 * 16 * CLK_PERIOD_NS;

    logic       clk;
    logic       rst_n;
    logic [3:0] key_sw;
    logic [3:0] led;
    seg_t       abcdefgh;
    digit_t     digit;
    logic       buzzer, hsync, vsync;
    logic [2:0] rgb;
    int         err_count;
    fp32_t      exp_sum [8];
    fp_flags_t  exp_flags [8];  // zero, pos_inf, neg_inf, nan

    top #(.REFRESH_BITS(REFRESH_BITS)) dut0
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .key_sw   ( key_sw   ),
        .led      ( led      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    ),
        .buzzer   ( buzzer   ),
        .hsync    ( hsync    ),
        .vsync    ( vsync    ),
        .rgb      ( rgb      )
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    // reference sums and classes for the eight table entries
    task automatic load_expected();
        exp_sum[0]   = 32'h0000_0000;
        exp_flags[0] = 4'b1000;  // 0 + 0 is zero
        exp_sum[1]   = 32'h3f80_0000;
        exp_flags[1] = 4'b0000;
        exp_sum[2]   = 32'h4000_0000;
        exp_flags[2] = 4'b0000;
        exp_sum[3]   = 32'h40dd_2f1a;
        exp_flags[3] = 4'b0000;
        exp_sum[4]   = 32'h538f_a811;
        exp_flags[4] = 4'b0000;  // small addend lost
        exp_sum[5]   = 32'h3f01_5435;
        exp_flags[5] = 4'b0000;
        exp_sum[6]   = 32'h7f80_0000;
        exp_flags[6] = 4'b0100;  // +inf
        exp_sum[7]   = 32'h7ffa_bcde;
        exp_flags[7] = 4'b0001;  // quiet nan kept
    endtask

    // segment pattern back to a nibble or -1 when no glyph matches
    function automatic int glyph_to_nibble(input seg_t pattern);
        seg_t glyphs [16];
        int   n;
        glyphs = '{8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
                   8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e};
        n = -1;
        for (int i = 0; i < 16; i++)
            if (seg_t'(~pattern) == glyphs[i])  // pins are active low
                n = i;
        return n;
    endfunction

    task automatic drive_keys(input logic [2:0] sel, input logic upper);
        @(posedge clk);
        #2;
        key_sw = {~sel, ~upper};  // pressed key reads low
    endtask

    // one pass over digits 0..3 with each sampled while lit
    task automatic read_display(output hex_word_t word);
        digit_t want;
        int     waited;
        int     nib;
        word = '0;
        for (int k = 0; k < 4; k++)
        begin
            want   = ~(digit_t'(1) << k);
            waited = 0;
            do
            begin
                @(posedge clk);
                #1;
                waited++;
            end
            while (digit != want && waited < READ_LIMIT);
            nib = glyph_to_nibble(abcdefgh);
            if (digit != want)
            begin
                $display("digit %0d was never enabled within %0d clocks", k, READ_LIMIT);
                err_count++;
            end
            else if (nib < 0)
            begin
                $display("segment pattern %b on digit %0d is not a hex digit", abcdefgh, k);
                err_count++;
            end
            else
                word[4*k +: 4] = nib[3:0];
        end
    endtask

    task automatic check_sums();
        hex_word_t hi, lo;
        for (int s = 0; s < 8; s++)
        begin
            drive_keys(3'(s), 1'b1);
            read_display(hi);
            drive_keys(3'(s), 1'b0);
            read_display(lo);
            if ({hi, lo} !== exp_sum[s])
            begin
                $display("ERR %0t: selection %0d shows sum %h, expected %h",
                         $time, s, {hi, lo}, exp_sum[s]);
                err_count++;
            end
        end
    endtask

    task automatic check_flags();
        for (int s = 0; s < 8; s++)
        begin
            drive_keys(3'(s), 1'b0);
            #5;  // combinational path settles in the same cycle
            if (led !== ~exp_flags[s])
            begin
                $display("ERR %0t: selection %0d led %b, expected %b",
                         $time, s, led, ~exp_flags[s]);
                err_count++;
            end
        end
    endtask

    task automatic check_half_select();
        hex_word_t w_hi, w_lo, w_hi2;
        drive_keys(3'd3, 1'b1);
        read_display(w_hi);
        drive_keys(3'd3, 1'b0);
        read_display(w_lo);
        drive_keys(3'd3, 1'b1);
        read_display(w_hi2);
        if (w_hi !== exp_sum[3][31:16] || w_lo !== exp_sum[3][15:0] || w_hi2 !== w_hi)
        begin
            $display("ERR %0t: half select gave %h / %h / %h for sum %h",
                     $time, w_hi, w_lo, w_hi2, exp_sum[3]);
            err_count++;
        end
    endtask

    task automatic check_scan_order();
        digit_t want;
        int     cnt;
        int     waited;
        waited = 0;
        // sync on the wrap from digit 3 so digit 0 is seen from its first clock
        while (digit != 4'b0111 && waited < READ_LIMIT)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        while (digit != 4'b1110 && waited < 2 * READ_LIMIT)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (digit != 4'b1110)
        begin
            $display("display scan never wrapped back to digit 0");
            err_count++;
        end
        else
        begin
            for (int k = 0; k < 4; k++)
            begin
                want = ~(digit_t'(1) << k);
                cnt  = 0;
                while (digit == want && cnt < READ_LIMIT)
                begin
                    cnt++;
                    @(posedge clk);
                    #1;
                end
                if (cnt != DIGIT_CLOCKS || digit != ~(digit_t'(1) << ((k + 1) % 4)))
                begin
                    $display("ERR %0t: digit %0d lit %0d clocks, then enables %b",
                             $time, k, cnt, digit);
                    err_count++;
                end
            end
        end
    endtask

    task automatic check_reset();
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        @(posedge clk);
        #1;
        if (digit !== 4'hf || abcdefgh !== 8'hff)
        begin
            $display("ERR %0t: in reset digit %b segments %b", $time, digit, abcdefgh);
            err_count++;
        end
        @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        if (digit !== 4'b1110)
        begin
            $display("ERR %0t: first digit after reset %b, expected 1110", $time, digit);
            err_count++;
        end
        repeat (DIGIT_CLOCKS) @(posedge clk);
        #1;
        if (digit !== 4'b1101)  // scan moved on to digit 1
        begin
            $display("ERR %0t: second digit after reset %b, expected 1101", $time, digit);
            err_count++;
        end
    endtask

    // buzzer and vga pins held inactive as on the board
    task automatic check_idle_pins();
        if (buzzer !== 1'b0 || hsync !== 1'b1 || vsync !== 1'b1 || rgb !== 3'b000)
        begin
            $display("ERR %0t: idle pins buzzer %b hsync %b vsync %b rgb %b",
                     $time, buzzer, hsync, vsync, rgb);
            err_count++;
        end
    endtask

    initial
    begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        key_sw    = 4'hf;  // nothing pressed
        err_count = 0;
        load_expected();
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_idle_pins();
        check_sums();
        check_flags();
        check_half_select();
        check_scan_order();
        check_reset();
        $display("%0d errors", err_count);
        if (err_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // stops a run whose display never answers
    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout, tests did not finish within %0d ns", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

endmodule

//--- build.f
fp_demo_pkg.sv
fp_operand_table.sv
fp_adder.sv
seven_segment_4_digits.sv
top.sv
fp_demo_checker.sv
tb_top.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_top
FILELIST = build.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
